// ==== keccak_pkg.sv ====
package keccak_pkg;

    // Lane width of Keccak-f[1600], one host word per lane
    localparam int LANE_W = 64;

    // Rate of each SHAKE variant in bits
    localparam int RATE_SHAKE128 = 1344;
    localparam int RATE_SHAKE256 = 1088;

    // Same rates counted in lanes
    localparam int DEPTH_SHAKE128 = RATE_SHAKE128 / LANE_W;
    localparam int DEPTH_SHAKE256 = RATE_SHAKE256 / LANE_W;

    // Mode code from header bits 62:61, unknown codes run as SHAKE128
    typedef logic [1:0] mode_t;
    localparam mode_t SHAKE128_MODE = 2'b00;
    localparam mode_t SHAKE256_MODE = 2'b01;

    // Widths with a meaning of their own
    typedef logic [4:0]               lane_count_t;
    typedef logic [31:0]              out_size_t;
    typedef logic [31:0]              msg_len_t;
    typedef logic [RATE_SHAKE128-1:0] rate_block_t;

    // SHAKE domain separation byte, then the closing bit of pad10*1
    localparam logic [7:0] DOMAIN_PAD = 8'h1F;
    localparam logic [7:0] FINAL_PAD  = 8'h80;

    // Host words arrive first byte on top, Keccak lanes want it at the bottom
    function automatic logic [LANE_W-1:0] byte_swap(input logic [LANE_W-1:0] word);
        logic [LANE_W-1:0] swapped;
        for (int i = 0; i < LANE_W / 8; i++) begin
            swapped[8*i +: 8] = word[LANE_W-8-8*i +: 8];
        end
        return swapped;
    endfunction

endpackage

// ==== size_counter.sv ====
`timescale 1ns/1ns

module size_counter #(
    parameter int W = 64
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 header_load,
    input  keccak_pkg::msg_len_t length_in,
    input  logic                 load_enable,
    output logic                 last_word,
    output logic [2:0]           remainder_bytes,
    output logic                 msg_done
);

    // Bit index above the byte offset within one word
    localparam int REM_MSB = $clog2(W) - 1;
    // Bits consumed per accepted word
    localparam keccak_pkg::msg_len_t STEP = keccak_pkg::msg_len_t'(W);

    // Message bits still to come from the host
    keccak_pkg::msg_len_t bits_left;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bits_left <= '0;
        end else if (header_load) begin
            bits_left <= length_in;
        end else if (load_enable) begin
            // Saturate at zero so padding words leave the count alone
            if (bits_left <= STEP) begin
                bits_left <= '0;
            end else begin
                bits_left <= bits_left - STEP;
            end
        end
    end

    // Word holding the final message bits
    assign last_word = (bits_left != '0) && (bits_left <= STEP);

    // Valid bytes in that word, a full word wraps to zero
    assign remainder_bytes = bits_left[REM_MSB:3];

    assign msg_done = (bits_left == '0);

endmodule

// ==== padding_generator.sv ====
`timescale 1ns/1ns

module padding_generator #(
    parameter int W = 64
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [W-1:0] data_in,
    input  logic         last_word,
    input  logic [2:0]   remainder_bytes,
    input  logic         msg_done,
    input  logic         last_lane,
    input  logic         padding_reset,
    output logic [W-1:0] data_out,
    output logic         last_block
);

    // Domain byte in the first byte position of a host word
    localparam logic [W-1:0] DOMAIN_TOP = {keccak_pkg::DOMAIN_PAD, {(W-8){1'b0}}};

    // Domain byte not yet placed for the current message
    logic         pad_pending;
    logic         partial_word;
    logic         fresh_domain;
    logic [W-1:0] keep_mask;
    logic [W-1:0] base_word;

    // Last word with spare bytes takes the domain byte itself
    assign partial_word = last_word && (remainder_bytes != 3'd0);
    // Full last word or empty message, domain byte opens a word of its own
    assign fresh_domain = msg_done && pad_pending;

    // Keep the valid high-order bytes only
    assign keep_mask = ~({W{1'b1}} >> {remainder_bytes, 3'b000});

    always_comb begin
        if (msg_done) begin
            // Pure padding word, zero once the domain byte is out
            base_word = pad_pending ? DOMAIN_TOP : '0;
        end else if (partial_word) begin
            base_word = (data_in & keep_mask) | (DOMAIN_TOP >> {remainder_bytes, 3'b000});
        end else begin
            base_word = data_in;
        end
    end

    // Final lane of the block that holds the domain byte closes the message
    assign last_block = last_lane && (!pad_pending || partial_word || fresh_domain);

    // Closing bit sits in the lowest host byte, top byte of the lane after the swap
    // and it merges with the domain byte when both land here
    assign data_out = last_block ? (base_word | {{(W-8){1'b0}}, keccak_pkg::FINAL_PAD})
                                 : base_word;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pad_pending <= 1'b0;
        end else if (padding_reset) begin
            // New header, the domain byte is owed again
            pad_pending <= 1'b1;
        end else if (partial_word || fresh_domain) begin
            pad_pending <= 1'b0;
        end
    end

endmodule

// ==== sipo_buffer.sv ====
`timescale 1ns/1ns

module sipo_buffer #(
    parameter int W     = 64,
    parameter int DEPTH = 21
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    en,
    input  logic [W-1:0]            data_in,
    output keccak_pkg::rate_block_t data_out
);

    // Lane storage, newest lane on top
    logic [W*DEPTH-1:0] lanes;

    // Each new lane enters at the top and pushes older lanes down,
    // after DEPTH shifts the first lane of the block sits at the bottom
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lanes <= '0;
        end else if (en) begin
            lanes <= {data_in, lanes[W*DEPTH-1:W]};
        end
    end

    assign data_out = lanes;

endmodule

// ==== load_datapath.sv ====
`timescale 1ns/1ns

module load_datapath #(
    parameter int W = 64
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    header_load,
    input  logic                    load_enable,
    input  logic                    padding_reset,
    input  logic [W-1:0]            data_in,
    output logic                    msg_done,
    output logic                    buffer_full,
    output logic                    last_input_block,
    output keccak_pkg::rate_block_t block_out,
    output keccak_pkg::mode_t       operation_mode,
    output keccak_pkg::out_size_t   output_size
);

    keccak_pkg::mode_t       mode_reg;
    keccak_pkg::lane_count_t fill_cnt;
    keccak_pkg::lane_count_t depth;
    logic                    last_lane;
    logic                    last_word;
    logic [2:0]              remainder_bytes;
    logic                    last_word_taken;
    logic                    pad_word_taken;
    logic [W-1:0]            padded_word;
    logic [W-1:0]            lane_le;
    keccak_pkg::rate_block_t buffer_out;

    // Header fields kept for the whole message
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_reg    <= keccak_pkg::SHAKE128_MODE;
            output_size <= '0;
        end else if (header_load) begin
            mode_reg    <= data_in[62:61];
            output_size <= {4'b0000, data_in[59:32]};
        end
    end

    // Header mode visible already in the load cycle
    assign operation_mode = header_load ? data_in[62:61] : mode_reg;

    // Lanes per block
    always_comb begin
        case (mode_reg)
            keccak_pkg::SHAKE128_MODE: depth = keccak_pkg::lane_count_t'(keccak_pkg::DEPTH_SHAKE128);
            keccak_pkg::SHAKE256_MODE: depth = keccak_pkg::lane_count_t'(keccak_pkg::DEPTH_SHAKE256);
            default:                   depth = keccak_pkg::lane_count_t'(keccak_pkg::DEPTH_SHAKE128);
        endcase
    end

    assign last_lane   = (fill_cnt == depth - 1'b1);
    // This write brings the fill count to the mode depth
    assign buffer_full = load_enable && last_lane;

    // Fill counter restarts at the edge that writes the last lane
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt <= '0;
        end else if (header_load || buffer_full) begin
            fill_cnt <= '0;
        end else if (load_enable) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    size_counter #(
        .W (W)
    ) u_size_counter (
        .clk             (clk),
        .rst_n           (rst_n),
        .header_load     (header_load),
        .length_in       (data_in[31:0]),
        .load_enable     (load_enable),
        .last_word       (last_word),
        .remainder_bytes (remainder_bytes),
        .msg_done        (msg_done)
    );

    // Padding only reacts to words actually shifted in
    assign last_word_taken = last_word && load_enable;
    assign pad_word_taken  = msg_done && load_enable;

    padding_generator #(
        .W (W)
    ) u_padding_generator (
        .clk             (clk),
        .rst_n           (rst_n),
        .data_in         (data_in),
        .last_word       (last_word_taken),
        .remainder_bytes (remainder_bytes),
        .msg_done        (pad_word_taken),
        .last_lane       (last_lane),
        .padding_reset   (padding_reset),
        .data_out        (padded_word),
        .last_block      (last_input_block)
    );

    // Little-endian lane order for the state
    assign lane_le = keccak_pkg::byte_swap(padded_word);

    sipo_buffer #(
        .W     (W),
        .DEPTH (keccak_pkg::DEPTH_SHAKE128)
    ) u_sipo_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (load_enable),
        .data_in  (lane_le),
        .data_out (buffer_out)
    );

    // SHAKE256 fills only the top 17 lanes
    // Shifting them down to lane 0 leaves the unused high lanes at zero
    assign block_out = (mode_reg == keccak_pkg::SHAKE256_MODE)
                     ? (buffer_out >> (keccak_pkg::RATE_SHAKE128 - keccak_pkg::RATE_SHAKE256))
                     : buffer_out;

    // A header only arrives between blocks
    header_between_blocks: assert property (@(posedge clk) disable iff (!rst_n)
        header_load |-> fill_cnt == '0)
        else $error("header while fill count is %0d", fill_cnt);

endmodule

// ==== load_control.sv ====
`timescale 1ns/1ns

module load_control (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic data_valid,
    input  logic msg_done,
    input  logic buffer_full,
    input  logic last_input_block,
    output logic header_load,
    output logic load_enable,
    output logic padding_reset,
    output logic need_data,
    output logic block_valid,
    output logic last_block,
    output logic busy,
    output logic done
);

    typedef enum logic [2:0] {
        IDLE,
        ABSORB,
        PAD,
        EMIT,
        FINISH
    } state_t;

    state_t state;
    state_t state_next;

    // Header accepted while idle or in the done cycle
    assign header_load   = start && ((state == IDLE) || (state == FINISH));
    // Padding state starts over with every header
    assign padding_reset = header_load;

    // Ask for words until the size counter runs out
    assign need_data = (state == ABSORB) && !msg_done;

    // Host words while data is needed
    // One padding word per cycle after that
    assign load_enable = (state == PAD) || ((state == ABSORB) && (msg_done || data_valid));

    assign block_valid = (state == EMIT);
    assign done        = (state == FINISH);
    assign busy        = (state == ABSORB) || (state == PAD) || (state == EMIT);

    always_comb begin
        state_next = state;
        case (state)
            IDLE, FINISH: begin
                state_next = start ? ABSORB : IDLE;
            end
            ABSORB: begin
                if (buffer_full) begin
                    state_next = EMIT;
                end else if (msg_done) begin
                    state_next = PAD;
                end
            end
            PAD: begin
                if (buffer_full) begin
                    state_next = EMIT;
                end
            end
            EMIT: begin
                // Next block starts straight after the hand-off cycle
                if (last_block) begin
                    state_next = FINISH;
                end else if (msg_done) begin
                    state_next = PAD;
                end else begin
                    state_next = ABSORB;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Last-block flag taken with the final lane write and held through EMIT
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_block <= 1'b0;
        end else if (header_load) begin
            last_block <= 1'b0;
        end else if (buffer_full) begin
            last_block <= last_input_block;
        end
    end

    // A block flagged last leaves no message words behind
    last_after_message: assert property (@(posedge clk) disable iff (!rst_n)
        (block_valid && last_block) |-> msg_done)
        else $error("last block handed off before the message ended");

    // Host only sends words that were asked for
    data_only_on_need: assert property (@(posedge clk) disable iff (!rst_n)
        (state != IDLE && data_valid) |-> need_data)
        else $error("data_valid while need_data is low");

endmodule

// ==== keccak_load_top.sv ====
`timescale 1ns/1ns

module keccak_load_top #(
    parameter int W = 64
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    data_valid,
    input  logic [W-1:0]            data_in,
    output logic                    need_data,
    output logic                    block_valid,
    output logic                    last_block,
    output keccak_pkg::rate_block_t block_out,
    output keccak_pkg::mode_t       operation_mode,
    output keccak_pkg::out_size_t   output_size,
    output logic                    busy,
    output logic                    done
);

    // Control strobes to the datapath
    logic header_load;
    logic load_enable;
    logic padding_reset;
    // Status back to the FSM
    logic msg_done;
    logic buffer_full;
    logic last_input_block;

    load_control u_load_control (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .data_valid       (data_valid),
        .msg_done         (msg_done),
        .buffer_full      (buffer_full),
        .last_input_block (last_input_block),
        .header_load      (header_load),
        .load_enable      (load_enable),
        .padding_reset    (padding_reset),
        .need_data        (need_data),
        .block_valid      (block_valid),
        .last_block       (last_block),
        .busy             (busy),
        .done             (done)
    );

    load_datapath #(
        .W (W)
    ) u_load_datapath (
        .clk              (clk),
        .rst_n            (rst_n),
        .header_load      (header_load),
        .load_enable      (load_enable),
        .padding_reset    (padding_reset),
        .data_in          (data_in),
        .msg_done         (msg_done),
        .buffer_full      (buffer_full),
        .last_input_block (last_input_block),
        .block_out        (block_out),
        .operation_mode   (operation_mode),
        .output_size      (output_size)
    );

endmodule

// ==== tb_keccak_load.sv ====
`timescale 1ns/1ns

module tb_keccak_load;

    localparam int W         = 64;
    localparam int BLOCK_W   = 1344;
    localparam int MAX_TESTS = 32;

    logic               clk;
    logic               rst_n;
    logic               start;
    logic               data_valid;
    logic [W-1:0]       data_in;
    logic               need_data;
    logic               block_valid;
    logic               last_block;
    logic [BLOCK_W-1:0] block_out;
    logic [1:0]         operation_mode;
    logic [31:0]        output_size;
    logic               busy;
    logic               done;

    // One entry per line of the vector file
    logic [1:0]  vec_mode [MAX_TESTS];
    logic [31:0] vec_len  [MAX_TESTS];
    logic [27:0] vec_size [MAX_TESTS];
    logic [7:0]  vec_gaps [MAX_TESTS];
    int          num_tests;

    // Expected hand-offs with the oldest first
    logic [BLOCK_W-1:0] exp_block [$];
    logic               exp_last  [$];
    logic [1:0]         exp_mode  [$];
    logic [W-1:0]       msg_words [$];

    logic [31:0] lfsr;
    logic        done_due;
    logic        vectors_ok;
    int          mismatches;
    int          failures;
    int          cycle_count;
    int          cycle_limit;

    keccak_load_top #(
        .W (W)
    ) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .data_valid     (data_valid),
        .data_in        (data_in),
        .need_data      (need_data),
        .block_valid    (block_valid),
        .last_block     (last_block),
        .block_out      (block_out),
        .operation_mode (operation_mode),
        .output_size    (output_size),
        .busy           (busy),
        .done           (done)
    );

    always #20 clk = ~clk;

    // Fibonacci LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per message bit with the first bit on top
    function automatic logic [W-1:0] random_word();
        logic [W-1:0] word;
        for (int b = W - 1; b >= 0; b--) begin
            lfsr    = lfsr_next(lfsr);
            word[b] = lfsr[0];
        end
        return word;
    endfunction

    // SHAKE256 rate is 136 bytes and every other code runs at 168
    function automatic int rate_bytes(input logic [1:0] mode);
        return (mode == 2'b01) ? 136 : 168;
    endfunction

    task automatic read_vectors(output logic ok);
        int          fd;
        string       line;
        logic [1:0]  m;
        logic [31:0] len;
        logic [27:0] sz;
        logic [7:0]  g;
        int          words;
        int          gaps;
        ok          = 1'b0;
        // Reset cycles plus slack
        cycle_limit = 20;
        fd = $fopen("keccak_load_input.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0 && num_tests < MAX_TESTS) begin
                // Comment and blank lines do not scan
                if ($sscanf(line, "%h %d %d %h", m, len, sz, g) == 4) begin
                    vec_mode[num_tests] = m;
                    vec_len[num_tests]  = len;
                    vec_size[num_tests] = sz;
                    vec_gaps[num_tests] = g;
                    words = (int'(len / 8) + 7) / 8;
                    gaps  = 0;
                    for (int i = 0; i < words; i++) begin
                        gaps += g[i % 8];
                    end
                    // Every lane and one emit cycle per block plus gaps and slack
                    cycle_limit += (int'(len / 8) / rate_bytes(m) + 1)
                                 * (rate_bytes(m) / 8 + 1) + gaps + 50;
                    num_tests++;
                end
            end
            $fclose(fd);
            ok = (num_tests > 0);
        end
    endtask

    // Reference padding on the byte stream
    // Block byte k sits at bits 8k+7:8k
    task automatic queue_expected(input logic [1:0] mode, input int len_bytes);
        int                 rate;
        int                 nblk;
        int                 idx;
        logic [7:0]         b;
        logic [W-1:0]       word;
        logic [BLOCK_W-1:0] blk_bits;
        rate = rate_bytes(mode);
        // A rate-multiple length gets a block of its own for the padding
        nblk = len_bytes / rate + 1;
        for (int blk = 0; blk < nblk; blk++) begin
            blk_bits = '0;
            for (int k = 0; k < rate; k++) begin
                idx = blk * rate + k;
                if (idx < len_bytes) begin
                    word = msg_words[idx / 8];
                    b    = word[W - 1 - 8 * (idx % 8) -: 8];
                end else if (idx == len_bytes) begin
                    b = 8'h1F;
                end else begin
                    b = 8'h00;
                end
                if (blk == nblk - 1 && k == rate - 1) begin
                    b = b | 8'h80;
                end
                blk_bits[8*k +: 8] = b;
            end
            exp_block.push_back(blk_bits);
            exp_last.push_back(blk == nblk - 1);
            exp_mode.push_back(mode);
        end
    endtask

    // Header and message words with gaps and then a wait for done
    task automatic send_message(input int t);
        int len_bytes;
        int nwords;
        len_bytes = int'(vec_len[t] / 8);
        nwords    = (len_bytes + 7) / 8;
        msg_words.delete();
        for (int i = 0; i < nwords; i++) begin
            msg_words.push_back(random_word());
        end
        queue_expected(vec_mode[t], len_bytes);
        start   = 1'b1;
        data_in = {1'b0, vec_mode[t], 1'b0, vec_size[t], vec_len[t]};
        @(posedge clk);
        #2;
        if (operation_mode !== vec_mode[t]) begin
            $display("MISMATCH at %0t: test %0d operation_mode %0d expected %0d",
                     $time, t, operation_mode, vec_mode[t]);
            mismatches++;
        end
        if (output_size !== {4'b0000, vec_size[t]}) begin
            $display("MISMATCH at %0t: test %0d output_size %0d expected %0d",
                     $time, t, output_size, vec_size[t]);
            mismatches++;
        end
        if (busy !== 1'b1) begin
            $display("Test %0d: busy did not rise after the header", t);
            failures++;
        end
        // An empty message never asks for data
        if (need_data !== (vec_len[t] != 0)) begin
            $display("Test %0d: need_data wrong in the cycle after the header", t);
            failures++;
        end
        start = 1'b0;
        for (int i = 0; i < nwords; i++) begin
            if (vec_gaps[t][i % 8]) begin
                @(posedge clk);
                #2;
            end
            while (need_data !== 1'b1) begin
                @(posedge clk);
                #2;
            end
            data_valid = 1'b1;
            data_in    = msg_words[i];
            @(posedge clk);
            #2;
            data_valid = 1'b0;
        end
        while (done !== 1'b1) begin
            if (need_data !== 1'b0) begin
                $display("Test %0d: need_data high after the last message word", t);
                failures++;
            end
            @(posedge clk);
            #2;
        end
        if (busy !== 1'b0) begin
            $display("Test %0d: busy still high in the done cycle", t);
            failures++;
        end
        if (exp_block.size() != 0) begin
            $display("Test %0d: done came with %0d blocks never handed off",
                     t, exp_block.size());
            failures++;
            exp_block.delete();
            exp_last.delete();
            exp_mode.delete();
        end
    endtask

    // Block hand-off and done checks on the cycle that just ended
    always @(posedge clk) begin : check_blocks
        int                 lane;
        logic [BLOCK_W-1:0] want;
        if (rst_n) begin
            if (done_due && done !== 1'b1) begin
                $display("Failure at %0t: done did not follow the last block", $time);
                failures++;
            end
            if (!done_due && done === 1'b1) begin
                $display("Failure at %0t: done without a last block before it", $time);
                failures++;
            end
            done_due = 1'b0;
            if (block_valid === 1'b1) begin
                if (need_data !== 1'b0) begin
                    $display("Failure at %0t: need_data high during block_valid", $time);
                    failures++;
                end
                if (exp_block.size() == 0) begin
                    $display("Failure at %0t: block_valid with no block expected", $time);
                    failures++;
                end else begin
                    want = exp_block.pop_front();
                    if (block_out !== want) begin
                        // Report the first lane that differs
                        lane = 0;
                        while (lane < 20 && block_out[64*lane +: 64] === want[64*lane +: 64]) begin
                            lane++;
                        end
                        $display("MISMATCH at %0t: lane %0d got %h expected %h", $time, lane,
                                 block_out[64*lane +: 64], want[64*lane +: 64]);
                        mismatches++;
                    end
                    if (last_block !== exp_last[0]) begin
                        $display("MISMATCH at %0t: last_block %b expected %b",
                                 $time, last_block, exp_last[0]);
                        mismatches++;
                    end
                    if (operation_mode !== exp_mode[0]) begin
                        $display("MISMATCH at %0t: block mode %0d expected %0d",
                                 $time, operation_mode, exp_mode[0]);
                        mismatches++;
                    end
                    done_due = exp_last.pop_front();
                    void'(exp_mode.pop_front());
                end
            end
        end
    end

    // Run limit from the vector lengths
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        data_valid  = 1'b0;
        data_in     = '0;
        lfsr        = 32'hb511_090f;
        done_due    = 1'b0;
        mismatches  = 0;
        failures    = 0;
        cycle_count = 0;
        num_tests   = 0;
        read_vectors(vectors_ok);
        if (!vectors_ok) begin
            $display("Could not read test vectors from keccak_load_input.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            #2;
            rst_n = 1'b1;
            if (need_data !== 1'b0 || block_valid !== 1'b0 || busy !== 1'b0 || done !== 1'b0) begin
                $display("Outputs not idle after reset");
                failures++;
            end
            for (int t = 0; t < num_tests; t++) begin
                send_message(t);
            end
            // Let the monitor see the last done cycle
            @(posedge clk);
            #2;
            $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
            if (mismatches == 0 && failures == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

// ==== keccak_load_input.txt ====
# mode(hex) length_bits(dec) output_size_bits(dec) gap_mask(hex)
# gap bit i inserts one idle cycle before words i, i+8, i+16 and so on
0 40 256 00
0 64 256 00
0 0 256 00
1 0 512 00
1 1088 512 00
1 1080 512 00
0 1336 256 00
0 1344 256 a5
0 3000 1024 5a
1 2504 4096 33
3 200 128 ff
1 8 100000 01
0 4104 8 c3

// ==== src.f ====
keccak_pkg.sv
size_counter.sv
padding_generator.sv
sipo_buffer.sv
load_datapath.sv
load_control.sv
keccak_load_top.sv
tb_keccak_load.sv

// ==== Makefile ====
TOP = tb_keccak_load

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP)

# Pass only when the simulation prints the pass line
run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module keccak_load_top

clean:
	rm -rf obj_dir
